// File: bench/tagger_chk.sv
// bound assertions on stream protocol and reset state at the tagger ports
`default_nettype none

module tagger_chk (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic s_tready_o,
	input wire tagger_pkg::data_t m_tdata_o,
	input wire tagger_pkg::keep_t m_tkeep_o,
	input wire logic m_tlast_o,
	input wire logic m_tvalid_o,
	input wire logic m_tready_i
);

	int fail_count = 0;                            // read by the testbench at the end

	// stalled output beat must stay put
	hold_out_beat: assert property (@(posedge clk) disable iff (rst_i)
		m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o)
			&& $stable(m_tkeep_o) && $stable(m_tlast_o))
	else begin
		fail_count++;
		$error("output beat changed or dropped while stalled");
	end

	// second reset cycle on, the registered handshakes are cleared
	reset_in_ready: assert property (@(posedge clk)
		rst_i && $past(rst_i) |-> !s_tready_o)
	else begin
		fail_count++;
		$error("input ready high during reset");
	end

	reset_out_valid: assert property (@(posedge clk)
		rst_i && $past(rst_i) |-> !m_tvalid_o)
	else begin
		fail_count++;
		$error("output valid high during reset");
	end

endmodule

`default_nettype wire

// File: bench/tb_axis_header_tagger.sv
// testbench for the header tagger with random packets, reference model, comparator and timeout
`default_nettype none

module tb_axis_header_tagger;
	import tagger_pkg::*;

	localparam int NUM_PKTS = 200;
	localparam int MIN_LEN = HEADER_BYTES + 1;     // header plus one payload byte
	localparam int MAX_LEN = 40;
	localparam int MAX_BEATS = 10;                 // longest packet in input beats
	localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_BEATS * 4;

	typedef logic [MAX_LEN*8-1:0] pkt_bytes_t;     // byte i in bits 8i+7:8i

	logic clk;
	logic rst_i;
	data_t s_tdata_i;
	keep_t s_tkeep_i;
	logic s_tlast_i;
	logic s_tvalid_i;
	logic s_tready_o;
	data_t m_tdata_o;
	keep_t m_tkeep_o;
	logic m_tlast_o;
	logic m_tvalid_o;
	logic m_tready_i;
	header_t header_o;

	pkt_bytes_t pkt_mem [NUM_PKTS];
	int pkt_len [NUM_PKTS];
	integer seed;
	int hdrs_sent;                                 // packets whose header beats were accepted
	int cycles = 0;

	axis_header_tagger axis_header_tagger_inst (
		.clk(clk),
		.rst_i(rst_i),
		.s_tdata_i(s_tdata_i),
		.s_tkeep_i(s_tkeep_i),
		.s_tlast_i(s_tlast_i),
		.s_tvalid_i(s_tvalid_i),
		.s_tready_o(s_tready_o),
		.m_tdata_o(m_tdata_o),
		.m_tkeep_o(m_tkeep_o),
		.m_tlast_o(m_tlast_o),
		.m_tvalid_o(m_tvalid_o),
		.m_tready_i(m_tready_i),
		.header_o(header_o)
	);

	bind axis_header_tagger tagger_chk chk_inst (
		.clk(clk),
		.rst_i(rst_i),
		.s_tready_o(s_tready_o),
		.m_tdata_o(m_tdata_o),
		.m_tkeep_o(m_tkeep_o),
		.m_tlast_o(m_tlast_o),
		.m_tvalid_o(m_tvalid_o),
		.m_tready_i(m_tready_i)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_header(input string name, input header_t exp, input header_t act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_keep(input string name, input keep_t exp, input keep_t act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_last(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
		end
	endtask

	// output beat b carries payload bytes 4b..4b+3, i.e. packet bytes from HEADER_BYTES on
	function automatic void model_beat(input pkt_bytes_t pkt, input int len, input int b,
			output header_t hdr, output data_t data, output keep_t keep, output logic last);
		int idx;
		hdr = pkt[HEADER_BYTES*8-1:0];             // byte 0 lowest
		data = '0;
		keep = '0;
		for (int k = 0; k < AXIS_BYTES; k++) begin
			idx = HEADER_BYTES + b * AXIS_BYTES + k;
			if (idx < len) begin
				data[k*8 +: 8] = pkt[idx*8 +: 8];
				keep[k] = 1'b1;
			end
		end
		last = (HEADER_BYTES + (b + 1) * AXIS_BYTES >= len);
	endfunction

	task automatic make_packets();
		logic [31:0] rnd;
		for (int p = 0; p < NUM_PKTS; p++) begin
			rnd = $random(seed);
			pkt_len[p] = MIN_LEN + int'(rnd % 32'(MAX_LEN - MIN_LEN + 1));
			for (int i = 0; i < MAX_LEN; i++) begin
				rnd = $random(seed);
				pkt_mem[p][i*8 +: 8] = rnd[7:0];
			end
		end
	endtask

	task automatic drive_packets();
		int nbeats;
		int idx;
		logic fired;
		logic [31:0] rnd;
		for (int p = 0; p < NUM_PKTS; p++) begin
			nbeats = (pkt_len[p] + AXIS_BYTES - 1) / AXIS_BYTES;
			for (int b = 0; b < nbeats; b++) begin
				rnd = $random(seed);
				while (rnd[1:0] == 2'b00) begin     // idle cycle before the beat
					s_tvalid_i = 1'b0;
					@(posedge clk);
					#1;
					rnd = $random(seed);
				end
				for (int k = 0; k < AXIS_BYTES; k++) begin
					idx = b * AXIS_BYTES + k;
					s_tkeep_i[k] = (idx < pkt_len[p]);
					s_tdata_i[k*8 +: 8] = (idx < pkt_len[p]) ? pkt_mem[p][idx*8 +: 8] : 8'h00;
				end
				s_tlast_i = (b == nbeats - 1);
				s_tvalid_i = 1'b1;
				fired = 1'b0;
				while (!fired) begin                // beat held until accepted
					@(negedge clk);
					fired = s_tready_o;
					@(posedge clk);
					#1;
				end
				if (b == HDR_BEATS - 1) begin
					hdrs_sent++;
				end
			end
		end
		s_tvalid_i = 1'b0;
	endtask

	task automatic compare_packets();
		int nbeats;
		logic seen;
		logic [31:0] rnd;
		header_t exp_hdr;
		data_t exp_data;
		keep_t exp_keep;
		logic exp_last;
		data_t byte_mask;
		string tag;
		for (int p = 0; p < NUM_PKTS; p++) begin
			nbeats = (pkt_len[p] - HEADER_BYTES + AXIS_BYTES - 1) / AXIS_BYTES;
			for (int b = 0; b < nbeats; b++) begin
				seen = 1'b0;
				while (!seen) begin
					@(posedge clk);
					#1;
					rnd = $random(seed);
					m_tready_i = (rnd[1:0] != 2'b00);   // about one stall in four
					@(negedge clk);
					if (m_tvalid_o && hdrs_sent <= p) begin
						fail_now($sformatf("output valid before header of packet %0d was sent", p));
					end
					seen = m_tvalid_o && m_tready_i;
				end
				model_beat(pkt_mem[p], pkt_len[p], b, exp_hdr, exp_data, exp_keep, exp_last);
				for (int k = 0; k < AXIS_BYTES; k++) begin
					byte_mask[k*8 +: 8] = {8{exp_keep[k]}};
				end
				tag = $sformatf("packet %0d beat %0d", p, b);
				check_header({tag, " header"}, exp_hdr, header_o);
				check_keep({tag, " keep"}, exp_keep, m_tkeep_o);
				check_data({tag, " data"}, exp_data, m_tdata_o & byte_mask);
				check_last({tag, " last"}, exp_last, m_tlast_o);
			end
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_now($sformatf("timeout after %0d cycles, packets not complete", cycles));
		end
	end

	initial begin
		rst_i = 1'b1;
		s_tdata_i = '0;
		s_tkeep_i = '0;
		s_tlast_i = 1'b0;
		s_tvalid_i = 1'b0;
		m_tready_i = 1'b0;
		hdrs_sent = 0;
		seed = 32'heeefa2c4;
		make_packets();
		repeat (8) @(posedge clk);
		#1;
		rst_i = 1'b0;
		fork
			drive_packets();
			compare_packets();
		join
		if (axis_header_tagger_inst.chk_inst.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			fail_now("stream protocol assertion failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/tagger_pkg.sv
hdl/axis_if.sv
hdl/axis_splitter.sv
hdl/header_collector.sv
hdl/axis_packer.sv
hdl/axis_header_tagger.sv
bench/tagger_chk.sv
bench/tb_axis_header_tagger.sv

// File: hdl/axis_header_tagger.sv
// header tagger top with splitter, header collector, payload gate and packer
`default_nettype none

module axis_header_tagger (
	input wire logic clk,
	input wire logic rst_i,

	input wire tagger_pkg::data_t s_tdata_i,        // packed input, header first
	input wire tagger_pkg::keep_t s_tkeep_i,
	input wire logic s_tlast_i,
	input wire logic s_tvalid_i,
	output logic s_tready_o,

	output tagger_pkg::data_t m_tdata_o,            // packed payload
	output tagger_pkg::keep_t m_tkeep_o,
	output logic m_tlast_o,
	output logic m_tvalid_o,
	input wire logic m_tready_i,
	output tagger_pkg::header_t header_o            // valid while the payload is on m_
);

	axis_if pkt_s ();
	axis_if hdr_s ();
	axis_if pay_s ();
	axis_if gated_s ();
	axis_if out_s ();

	logic header_valid;
	logic release_hdr;

	assign pkt_s.tdata = s_tdata_i;
	assign pkt_s.tkeep = s_tkeep_i;
	assign pkt_s.tlast = s_tlast_i;
	assign pkt_s.tvalid = s_tvalid_i;
	assign s_tready_o = pkt_s.tready;

	axis_splitter splitter_inst (
		.clk(clk),
		.rst_i(rst_i),
		.in_s(pkt_s),
		.hdr_o(hdr_s),
		.pay_o(pay_s)
	);

	header_collector collector_inst (
		.clk(clk),
		.rst_i(rst_i),
		.hdr_s(hdr_s),
		.release_i(release_hdr),
		.header_valid_o(header_valid),
		.header_o(header_o)
	);

	// payload only moves on while its header is held
	assign gated_s.tvalid = pay_s.tvalid && header_valid;
	assign pay_s.tready = gated_s.tready && header_valid;
	assign gated_s.tdata = pay_s.tdata;
	assign gated_s.tkeep = pay_s.tkeep;
	assign gated_s.tlast = pay_s.tlast;

	axis_packer packer_inst (
		.clk(clk),
		.rst_i(rst_i),
		.in_s(gated_s),
		.out_o(out_s)
	);

	assign m_tdata_o = out_s.tdata;
	assign m_tkeep_o = out_s.tkeep;
	assign m_tlast_o = out_s.tlast;
	assign m_tvalid_o = out_s.tvalid;
	assign out_s.tready = m_tready_i;

	assign release_hdr = m_tvalid_o && m_tlast_o && m_tready_i;  // packet fully out

endmodule

`default_nettype wire

// File: hdl/axis_if.sv
// valid/ready byte stream interface with source and sink modports
`default_nettype none

interface axis_if;
	import tagger_pkg::*;

	data_t tdata;                                   // byte k in bits 8k+7:8k
	keep_t tkeep;                                   // one bit per byte lane
	logic tlast;
	logic tvalid;
	logic tready;

	modport source (
		output tdata,
		output tkeep,
		output tlast,
		output tvalid,
		input tready
	);

	modport sink (
		input tdata,
		input tkeep,
		input tlast,
		input tvalid,
		output tready
	);

endinterface

`default_nettype wire

// File: hdl/axis_packer.sv
// packer compacting payload beats with leading byte holes into fully packed output beats
`default_nettype none

module axis_packer (
	input wire logic clk,
	input wire logic rst_i,
	axis_if.sink in_s,
	axis_if.source out_o
);
	import tagger_pkg::*;

	residue_t res_q;                                // bytes waiting for a full beat
	logic [LANE_CNT_W-1:0] res_cnt_q;
	logic flush_q;                                  // residue is the packet tail
	logic out_valid_q;
	data_t out_data_q;
	keep_t out_keep_q;
	logic out_last_q;

	pair_t cat;
	logic [LANE_CNT_W-1:0] total;
	logic out_free;
	logic accept;
	logic load_out;
	data_t nxt_data;
	keep_t nxt_keep;
	logic nxt_last;
	residue_t nxt_res;
	logic [LANE_CNT_W-1:0] nxt_cnt;
	logic nxt_flush;
	int pos;

	function automatic keep_t low_keep(input logic [LANE_CNT_W-1:0] n);
		keep_t m;
		for (int k = 0; k < AXIS_BYTES; k++) begin
			m[k] = (k < int'(n));
		end
		return m;
	endfunction

	assign out_free = !out_valid_q || out_o.tready;
	assign in_s.tready = !flush_q && out_free;
	assign accept = in_s.tvalid && !flush_q && out_free;

	// residue first, then the kept input bytes packed behind it
	always_comb begin
		cat = pair_t'(res_q);
		pos = int'(res_cnt_q);
		for (int k = 0; k < AXIS_BYTES; k++) begin
			if (in_s.tkeep[k]) begin
				cat[pos*8 +: 8] = in_s.tdata[k*8 +: 8];
				pos = pos + 1;
			end
		end
		total = LANE_CNT_W'(pos);
	end

	always_comb begin
		load_out = 1'b0;
		nxt_data = cat[DATA_W-1:0];
		nxt_keep = '1;
		nxt_last = 1'b0;
		nxt_res = res_q;
		nxt_cnt = res_cnt_q;
		nxt_flush = flush_q;
		if (flush_q) begin
			if (out_free) begin                     // second beat of a split tail
				load_out = 1'b1;
				nxt_data = data_t'(res_q);
				nxt_keep = low_keep(res_cnt_q);
				nxt_last = 1'b1;
				nxt_cnt = '0;
				nxt_flush = 1'b0;
			end
		end else if (accept) begin
			if (total >= LANE_CNT_W'(AXIS_BYTES)) begin
				load_out = 1'b1;
				nxt_res = cat[DATA_W +: RES_W];
				nxt_cnt = total - LANE_CNT_W'(AXIS_BYTES);
				nxt_last = in_s.tlast && (nxt_cnt == '0);
				nxt_flush = in_s.tlast && (nxt_cnt != '0);
			end else if (in_s.tlast) begin
				load_out = 1'b1;                    // short tail fits in one beat
				nxt_keep = low_keep(total);
				nxt_last = 1'b1;
				nxt_cnt = '0;
			end else begin
				nxt_res = cat[RES_W-1:0];
				nxt_cnt = total;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			out_valid_q <= 1'b0;
			res_cnt_q <= '0;
			flush_q <= 1'b0;
		end else begin
			if (load_out) begin
				out_valid_q <= 1'b1;
			end else if (out_o.tready) begin
				out_valid_q <= 1'b0;
			end
			res_cnt_q <= nxt_cnt;
			flush_q <= nxt_flush;
		end
	end

	always_ff @(posedge clk) begin
		res_q <= nxt_res;
		if (load_out) begin
			out_data_q <= nxt_data;
			out_keep_q <= nxt_keep;
			out_last_q <= nxt_last;
		end
	end

	assign out_o.tvalid = out_valid_q;
	assign out_o.tdata = out_data_q;
	assign out_o.tkeep = out_keep_q;
	assign out_o.tlast = out_last_q;

endmodule

`default_nettype wire

// File: hdl/axis_splitter.sv
// splitter routing the header bytes and the payload bytes of each packet to two streams
`default_nettype none

module axis_splitter (
	input wire logic clk,
	input wire logic rst_i,
	axis_if.sink in_s,
	axis_if.source hdr_o,
	axis_if.source pay_o
);
	import tagger_pkg::*;

	split_state_t state_q;
	logic [BEAT_CNT_W-1:0] beat_q;                  // beat number inside the header
	logic hdr_sent_q;                               // header part of current beat taken
	keep_t hdr_mask;
	keep_t hdr_keep;
	keep_t pay_keep;
	logic need_hdr;
	logic need_pay;
	logic hdr_pend;
	logic in_fire;
	logic hdr_fire;

	// lanes of the current beat that still fall inside the header
	always_comb begin
		hdr_mask = '0;
		if (state_q == in_header) begin
			for (int k = 0; k < AXIS_BYTES; k++) begin
				if (int'(beat_q) * AXIS_BYTES + k < HEADER_BYTES) begin
					hdr_mask[k] = 1'b1;
				end
			end
		end
	end

	assign hdr_keep = in_s.tkeep & hdr_mask;
	assign pay_keep = in_s.tkeep & ~hdr_mask;
	assign need_hdr = |hdr_keep;
	assign need_pay = |pay_keep;
	assign hdr_pend = need_hdr && !hdr_sent_q;

	// A beat that straddles the header end hands its header bytes over first.
	// Its payload bytes follow once the collector has the whole header, which
	// is what opens the payload gate at the top level.
	assign hdr_o.tvalid = in_s.tvalid && hdr_pend;
	assign hdr_o.tdata = in_s.tdata;
	assign hdr_o.tkeep = hdr_keep;
	assign hdr_o.tlast = 1'b0;                      // header never ends a packet

	assign pay_o.tvalid = in_s.tvalid && need_pay && !hdr_pend;
	assign pay_o.tdata = in_s.tdata;
	assign pay_o.tkeep = pay_keep;
	assign pay_o.tlast = in_s.tlast;

	assign in_s.tready = hdr_pend ? (hdr_o.tready && !need_pay) : pay_o.tready;

	assign in_fire = in_s.tvalid && in_s.tready;
	assign hdr_fire = hdr_o.tvalid && hdr_o.tready;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= in_header;
			beat_q <= '0;
			hdr_sent_q <= 1'b0;
		end else begin
			if (in_fire) begin
				hdr_sent_q <= 1'b0;
				if (in_s.tlast) begin
					state_q <= in_header;           // next packet starts with its header
					beat_q <= '0;
				end else if (state_q == in_header) begin
					if (beat_q == BEAT_CNT_W'(HDR_BEATS - 1)) begin
						state_q <= in_payload;
						beat_q <= '0;
					end else begin
						beat_q <= beat_q + BEAT_CNT_W'(1);
					end
				end
			end else if (hdr_fire) begin
				hdr_sent_q <= 1'b1;                 // payload lanes still pending
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/header_collector.sv
// header collector assembling the header word and holding it until the packet has left
`default_nettype none

module header_collector (
	input wire logic clk,
	input wire logic rst_i,
	axis_if.sink hdr_s,
	input wire logic release_i,
	output logic header_valid_o,
	output tagger_pkg::header_t header_o
);
	import tagger_pkg::*;

	header_t header_q;
	header_t header_d;
	logic [HDR_CNT_W-1:0] cnt_q;                    // header bytes gathered so far
	logic valid_q;
	logic ready_q;
	logic hdr_fire;
	logic hdr_done;
	int fill;

	assign hdr_s.tready = ready_q;
	assign hdr_fire = hdr_s.tvalid && ready_q;
	assign header_valid_o = valid_q;
	assign header_o = header_q;

	// kept bytes land at consecutive header positions, byte 0 lowest
	always_comb begin
		header_d = header_q;
		fill = int'(cnt_q);
		for (int k = 0; k < AXIS_BYTES; k++) begin
			if (hdr_s.tkeep[k] && fill < HEADER_BYTES) begin
				header_d[fill*8 +: 8] = hdr_s.tdata[k*8 +: 8];
				fill = fill + 1;
			end
		end
		hdr_done = (fill >= HEADER_BYTES);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
			ready_q <= 1'b0;
			cnt_q <= '0;
		end else if (valid_q) begin
			if (release_i) begin                    // last output beat of the packet left
				valid_q <= 1'b0;
				ready_q <= 1'b1;
			end
		end else begin
			ready_q <= 1'b1;
			if (hdr_fire) begin
				if (hdr_done) begin
					valid_q <= 1'b1;
					ready_q <= 1'b0;                // next header waits for release
					cnt_q <= '0;
				end else begin
					cnt_q <= HDR_CNT_W'(fill);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_fire) begin
			header_q <= header_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tagger_pkg.sv
// beat and header widths, derived counter widths, vector types and the splitter state enum
`default_nettype none

package tagger_pkg;

	localparam int AXIS_BYTES = 4;                  // stream width in bytes
	localparam int HEADER_BYTES = 6;                // header length in bytes
	localparam int DATA_W = AXIS_BYTES * 8;

	// input beats that carry at least one header byte
	localparam int HDR_BEATS = (HEADER_BYTES + AXIS_BYTES - 1) / AXIS_BYTES;

	localparam int BEAT_CNT_W = $clog2(HDR_BEATS + 1);    // splitter beat counter
	localparam int HDR_CNT_W = $clog2(HEADER_BYTES + 1);  // collector byte index
	localparam int LANE_CNT_W = $clog2(2 * AXIS_BYTES);   // packer byte count, residue plus beat
	localparam int RES_W = (AXIS_BYTES - 1) * 8;          // packer residue bits

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [AXIS_BYTES-1:0] keep_t;
	typedef logic [HEADER_BYTES*8-1:0] header_t;
	typedef logic [RES_W-1:0] residue_t;
	typedef logic [2*DATA_W-1:0] pair_t;            // residue joined with one beat

	typedef enum logic {
		in_header,                                  // bytes still belong to the header
		in_payload                                  // header done, rest of packet is payload
	} split_state_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the header tagger testbench with Verilator.

cd "$(dirname "$0")" || exit 1

TOP=tb_axis_header_tagger
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -Mdir obj_dir -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

echo "simulation finished without failure"
exit 0
